// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = rv_core_tb
FILELIST  = project.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)

// File: design/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
  input  rv_pkg::branch_e i_kind,
  input  rv_pkg::word_t   i_pc,
  input  rv_pkg::word_t   i_rs1_data,
  input  rv_pkg::word_t   i_rs2_data,
  input  rv_pkg::word_t   i_imm,
  output logic            o_taken,
  output rv_pkg::word_t   o_target
);
  import rv_pkg::*;

  logic eq;
  logic lt;
  logic ltu;
  word_t jalr_sum;

  assign eq = (i_rs1_data == i_rs2_data);
  assign lt = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign ltu = i_rs1_data < i_rs2_data;
  assign jalr_sum = i_rs1_data + i_imm;

  always_comb begin
    case (i_kind)
      BR_BEQ: o_taken = eq;
      BR_BNE: o_taken = !eq;
      BR_BLT: o_taken = lt;
      BR_BGE: o_taken = !lt;
      BR_BLTU: o_taken = ltu;
      BR_BGEU: o_taken = !ltu;
      BR_JAL, BR_JALR: o_taken = 1'b1;
      default: o_taken = 1'b0;
    endcase
  end

  // JALR target is word aligned by dropping the low two bits
  assign o_target = (i_kind == BR_JALR) ? {jalr_sum[XLEN-1:2], 2'b00} : i_pc + i_imm;

endmodule

// File: design/commit_stage.sv
`timescale 1ns/1ps

module commit_stage #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::wb_sel_e  i_wb_sel,
  input  rv_pkg::reg_idx_t i_rd,
  input  rv_pkg::word_t    i_alu_result,
  input  rv_pkg::word_t    i_rs2_data,
  input  rv_pkg::word_t    i_target,
  input  logic             i_taken,
  input  logic             i_store,
  input  logic             i_halt_req,
  output rv_pkg::word_t    o_pc,
  output logic             o_rf_we,
  output rv_pkg::word_t    o_rf_wdata,
  output rv_pkg::word_t    o_dmem_addr,
  output rv_pkg::word_t    o_dmem_wdata,
  output logic             o_dmem_we,
  output logic             o_halt
);
  import rv_pkg::*;

  word_t pc_q;
  word_t pc_plus4;
  logic active;

  assign pc_plus4 = pc_q + word_t'(4);
  // No side effects in reset or while halted on ECALL
  assign active = !rst && !i_halt_req;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else if (!i_halt_req) begin
      pc_q <= i_taken ? i_target : pc_plus4;
    end
  end

  assign o_pc = pc_q;
  assign o_halt = i_halt_req && !rst;

  assign o_rf_wdata = (i_wb_sel == WB_LINK) ? pc_plus4 : i_alu_result;
  assign o_rf_we = active && (i_wb_sel != WB_NONE) && (i_rd != '0);

  // Misaligned SW is dropped
  assign o_dmem_addr = i_alu_result;
  assign o_dmem_wdata = i_rs2_data;
  assign o_dmem_we = active && i_store && (i_alu_result[1:0] == 2'b00);

  a_pc_aligned: assert property (@(posedge clk) disable iff (rst) o_pc[1:0] == 2'b00);

endmodule

// File: design/insn_decoder.sv
`timescale 1ns/1ps

module insn_decoder (
  input  rv_pkg::word_t    i_insn,
  output rv_pkg::reg_idx_t o_rs1,
  output rv_pkg::reg_idx_t o_rs2,
  output rv_pkg::reg_idx_t o_rd,
  output rv_pkg::word_t    o_imm,
  output rv_pkg::alu_op_e  o_alu_op,
  output logic             o_a_is_pc,
  output logic             o_b_is_imm,
  output rv_pkg::branch_e  o_branch,
  output rv_pkg::wb_sel_e  o_wb_sel,
  output logic             o_store,
  output logic             o_halt_req
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;
  word_t imm_u;
  logic is_imm;
  logic f7_zero;
  logic f7_alt;
  alu_op_e arith_op;
  logic arith_ok;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd = i_insn[11:7];
  assign o_rs1 = i_insn[19:15];
  assign o_rs2 = i_insn[24:20];

  // Sign-extended immediates per format
  assign imm_i = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{(XLEN-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{(XLEN-13){i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25],
                  i_insn[11:8], 1'b0};
  assign imm_j = {{(XLEN-21){i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20],
                  i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  assign is_imm = (opcode == OPC_OP_IMM);
  assign f7_zero = (funct7 == 7'b0000000);
  assign f7_alt = (funct7 == 7'b0100000);

  // Shared funct3/funct7 decode for OP and OP_IMM
  always_comb begin
    arith_op = ALU_ADD;
    arith_ok = is_imm || f7_zero;
    case (funct3)
      3'b000: begin
        arith_op = (!is_imm && f7_alt) ? ALU_SUB : ALU_ADD;
        arith_ok = is_imm || f7_zero || f7_alt;
      end
      3'b001: begin
        arith_op = ALU_SLL;
        arith_ok = f7_zero;
      end
      3'b010: arith_op = ALU_SLT;
      3'b011: arith_op = ALU_SLTU;
      3'b100: arith_op = ALU_XOR;
      3'b101: begin
        arith_op = f7_alt ? ALU_SRA : ALU_SRL;
        arith_ok = f7_zero || f7_alt;
      end
      3'b110: arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    o_imm = imm_i;
    o_alu_op = ALU_ADD;
    o_a_is_pc = 1'b0;
    o_b_is_imm = 1'b0;
    o_branch = BR_NONE;
    o_wb_sel = WB_NONE;
    o_store = 1'b0;
    o_halt_req = 1'b0;
    case (opcode)
      OPC_LUI: begin
        o_imm = imm_u;
        o_alu_op = ALU_PASS_B;
        o_b_is_imm = 1'b1;
        o_wb_sel = WB_ALU;
      end
      OPC_AUIPC: begin
        o_imm = imm_u;
        o_a_is_pc = 1'b1;
        o_b_is_imm = 1'b1;
        o_wb_sel = WB_ALU;
      end
      OPC_JAL: begin
        o_imm = imm_j;
        o_branch = BR_JAL;
        o_wb_sel = WB_LINK;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          o_branch = BR_JALR;
          o_wb_sel = WB_LINK;
        end
      end
      OPC_BRANCH: begin
        o_imm = imm_b;
        case (funct3)
          3'b000: o_branch = BR_BEQ;
          3'b001: o_branch = BR_BNE;
          3'b100: o_branch = BR_BLT;
          3'b101: o_branch = BR_BGE;
          3'b110: o_branch = BR_BLTU;
          3'b111: o_branch = BR_BGEU;
          default: o_branch = BR_NONE;
        endcase
      end
      OPC_STORE: begin
        // Only SW, address formed in the ALU
        o_imm = imm_s;
        o_b_is_imm = 1'b1;
        o_store = (funct3 == 3'b010);
      end
      OPC_OP_IMM, OPC_OP: begin
        o_alu_op = arith_op;
        o_b_is_imm = is_imm;
        o_wb_sel = arith_ok ? WB_ALU : WB_NONE;
      end
      OPC_MISC_MEM: begin
        // FENCE has nothing to order here
      end
      OPC_SYSTEM: begin
        o_halt_req = (i_insn[31:7] == '0);
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    assert ($onehot0({o_store, o_halt_req, o_wb_sel != WB_NONE}))
      else $error("decoder raised more than one effect for %h", i_insn);
  end

endmodule

// File: design/int_alu.sv
`timescale 1ns/1ps

module int_alu (
  input  rv_pkg::alu_op_e i_op,
  input  rv_pkg::word_t   i_a,
  input  rv_pkg::word_t   i_b,
  output rv_pkg::word_t   o_result
);
  import rv_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN);

  logic [SHAMT_W-1:0] shamt;
  logic lt_signed;
  logic lt_unsigned;

  assign shamt = i_b[SHAMT_W-1:0];
  assign lt_signed = $signed(i_a) < $signed(i_b);
  assign lt_unsigned = i_a < i_b;

  always_comb begin
    case (i_op)
      ALU_ADD: o_result = i_a + i_b;
      ALU_SUB: o_result = i_a - i_b;
      ALU_SLL: o_result = i_a << shamt;
      // Compares give zero or one
      ALU_SLT: o_result = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: o_result = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_XOR: o_result = i_a ^ i_b;
      ALU_SRL: o_result = i_a >> shamt;
      ALU_SRA: o_result = word_t'($signed(i_a) >>> shamt);
      ALU_OR: o_result = i_a | i_b;
      ALU_AND: o_result = i_a & i_b;
      ALU_PASS_B: o_result = i_b;
      default: o_result = '0;
    endcase
  end

endmodule

// File: design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::reg_idx_t i_rs1,
  input  rv_pkg::reg_idx_t i_rs2,
  input  rv_pkg::reg_idx_t i_rd,
  input  logic             i_we,
  input  rv_pkg::word_t    i_wdata,
  output rv_pkg::word_t    o_rs1_data,
  output rv_pkg::word_t    o_rs2_data
);
  import rv_pkg::*;

  word_t regs [NUM_REGS];

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // Entry 0 is cleared on reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_wdata;
    end
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (rst)
    (i_rs1 == '0) |-> (o_rs1_data == '0));

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter rv_pkg::word_t RESET_PC = '0
) (
  input  logic          clk,
  input  logic          rst,
  input  rv_pkg::word_t i_insn,
  output rv_pkg::word_t o_pc,
  output rv_pkg::word_t o_dmem_addr,
  output rv_pkg::word_t o_dmem_wdata,
  output logic          o_dmem_we,
  output logic          o_halt
);
  import rv_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t imm;
  alu_op_e alu_op;
  logic a_is_pc;
  logic b_is_imm;
  branch_e branch;
  wb_sel_e wb_sel;
  logic store;
  logic halt_req;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  logic taken;
  word_t target;
  logic rf_we;
  word_t rf_wdata;

  insn_decoder decoder_i (
    .i_insn     (i_insn),
    .o_rs1      (rs1),
    .o_rs2      (rs2),
    .o_rd       (rd),
    .o_imm      (imm),
    .o_alu_op   (alu_op),
    .o_a_is_pc  (a_is_pc),
    .o_b_is_imm (b_is_imm),
    .o_branch   (branch),
    .o_wb_sel   (wb_sel),
    .o_store    (store),
    .o_halt_req (halt_req)
  );

  reg_file reg_file_i (
    .clk        (clk),
    .rst        (rst),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_rd       (rd),
    .i_we       (rf_we),
    .i_wdata    (rf_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  // Operand selects, PC for AUIPC and immediate for I/S/U forms
  assign alu_a = a_is_pc ? o_pc : rs1_data;
  assign alu_b = b_is_imm ? imm : rs2_data;

  int_alu alu_i (
    .i_op     (alu_op),
    .i_a      (alu_a),
    .i_b      (alu_b),
    .o_result (alu_result)
  );

  branch_unit branch_i (
    .i_kind     (branch),
    .i_pc       (o_pc),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_imm      (imm),
    .o_taken    (taken),
    .o_target   (target)
  );

  commit_stage #(
    .RESET_PC (RESET_PC)
  ) commit_i (
    .clk          (clk),
    .rst          (rst),
    .i_wb_sel     (wb_sel),
    .i_rd         (rd),
    .i_alu_result (alu_result),
    .i_rs2_data   (rs2_data),
    .i_target     (target),
    .i_taken      (taken),
    .i_store      (store),
    .i_halt_req   (halt_req),
    .o_pc         (o_pc),
    .o_rf_we      (rf_we),
    .o_rf_wdata   (rf_wdata),
    .o_dmem_addr  (o_dmem_addr),
    .o_dmem_wdata (o_dmem_wdata),
    .o_dmem_we    (o_dmem_we),
    .o_halt       (o_halt)
  );

endmodule

// File: design/rv_pkg.sv
package rv_pkg;

  // Datapath width and architectural register count
  localparam int XLEN = 32;
  localparam int NUM_REGS = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

  // Major opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_LUI      = 7'b0110111,
    OPC_AUIPC    = 7'b0010111,
    OPC_JAL      = 7'b1101111,
    OPC_JALR     = 7'b1100111,
    OPC_BRANCH   = 7'b1100011,
    OPC_STORE    = 7'b0100011,
    OPC_OP_IMM   = 7'b0010011,
    OPC_OP       = 7'b0110011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    // Operand b straight through, used by LUI
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE,
    BR_BEQ,
    BR_BNE,
    BR_BLT,
    BR_BGE,
    BR_BLTU,
    BR_BGEU,
    BR_JAL,
    BR_JALR
  } branch_e;

  // Writeback source for rd
  typedef enum logic [1:0] {
    WB_NONE,
    WB_ALU,
    WB_LINK
  } wb_sel_e;

endpackage

// File: project.f
+incdir+test
design/rv_pkg.sv
design/insn_decoder.sv
design/reg_file.sv
design/int_alu.sv
design/branch_unit.sv
design/commit_stage.sv
design/rv_core.sv
test/rv_core_tb.sv

// File: test/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Architectural state of the reference model
word_t m_regs [NUM_REGS];
word_t m_pc;
logic  exp_we;
logic  exp_halt;
word_t exp_addr;
word_t exp_wdata;
word_t lfsr_state;

// Fibonacci LFSR, taps 32 22 2 1, one step per returned bit
function automatic word_t lfsr_bits(input int bits);
  word_t v;
  logic fb;
  v = '0;
  for (int i = 0; i < bits; i++) begin
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[XLEN-2:0], fb};
    v = {v[XLEN-2:0], fb};
  end
  return v;
endfunction

function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return {31'd0, $signed(a) < $signed(b)};
    3'b011: return {31'd0, a < b};
    3'b100: return a ^ b;
    3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic branch_model(input logic [2:0] f3, input word_t a, input word_t b);
  case (f3)
    3'b000: return a == b;
    3'b001: return a != b;
    3'b100: return $signed(a) < $signed(b);
    3'b101: return $signed(a) >= $signed(b);
    3'b110: return a < b;
    3'b111: return a >= b;
    default: return 1'b0;
  endcase
endfunction

function automatic void model_reset();
  m_pc = '0;
  for (int i = 0; i < NUM_REGS; i++) begin
    m_regs[i] = '0;
  end
endfunction

// Executes one instruction and leaves the expected port values behind
function automatic void model_step(input word_t insn);
  word_t a;
  word_t b;
  word_t r;
  word_t nxt;
  word_t imm_i;
  word_t imm_s;
  word_t imm_b;
  word_t imm_j;
  logic [2:0] f3;
  logic wr;
  f3 = insn[14:12];
  a = m_regs[insn[19:15]];
  b = m_regs[insn[24:20]];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  nxt = m_pc + 32'd4;
  r = '0;
  wr = 1'b0;
  exp_we = 1'b0;
  exp_halt = 1'b0;
  case (insn[6:0])
    OPC_LUI: begin
      r = {insn[31:12], 12'd0};
      wr = 1'b1;
    end
    OPC_AUIPC: begin
      r = m_pc + {insn[31:12], 12'd0};
      wr = 1'b1;
    end
    OPC_JAL: begin
      r = m_pc + 32'd4;
      wr = 1'b1;
      nxt = m_pc + imm_j;
    end
    OPC_JALR: begin
      r = m_pc + 32'd4;
      wr = 1'b1;
      nxt = (a + imm_i) & 32'hffff_fffc;
    end
    OPC_BRANCH: begin
      if (branch_model(f3, a, b)) begin
        nxt = m_pc + imm_b;
      end
    end
    OPC_STORE: begin
      exp_addr = a + imm_s;
      exp_wdata = b;
      exp_we = (exp_addr[1:0] == 2'b00);
    end
    OPC_OP_IMM: begin
      r = alu_model(f3, insn[30] && (f3 == 3'b101), a, imm_i);
      wr = 1'b1;
    end
    OPC_OP: begin
      r = alu_model(f3, insn[30], a, b);
      wr = 1'b1;
    end
    default: begin
      if (insn == 32'h0000_0073) begin
        exp_halt = 1'b1;
        nxt = m_pc;
      end
    end
  endcase
  if (wr && insn[11:7] != 5'd0) begin
    m_regs[insn[11:7]] = r;
  end
  m_pc = nxt;
endfunction

`endif

// File: test/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
  import rv_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_WORDS = 256;
  localparam int NUM_TESTS = 6;
  localparam int HOLD_CYCLES = 6;
  localparam word_t SEED = 32'h9d54_0c27;
  localparam word_t ECALL = 32'h0000_0073;
  localparam logic [2:0] BR_F3 [6] = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};

  logic clk;
  logic rst;
  word_t insn;
  word_t pc;
  word_t dmem_addr;
  word_t dmem_wdata;
  logic dmem_we;
  logic halt;

  word_t prog [MAX_WORDS];
  int prog_len;
  int errors;
  int checks;

  `include "core_model.svh"

  rv_core #(
    .RESET_PC (32'h0)
  ) rv_core_i (
    .clk          (clk),
    .rst          (rst),
    .i_insn       (insn),
    .o_pc         (pc),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .o_halt       (halt)
  );

  // Fetch straight from the program array
  assign insn = prog[pc[9:2]];

  function automatic word_t enc_i(input word_t imm, input reg_idx_t rs1, input logic [2:0] f3,
                                  input reg_idx_t rd, input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3, input reg_idx_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t enc_s(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t enc_b(input word_t imm, input reg_idx_t rs2, input reg_idx_t rs1,
                                  input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic word_t enc_u(input word_t imm, input reg_idx_t rd, input logic [6:0] op);
    return {imm[19:0], rd, op};
  endfunction

  function automatic word_t enc_j(input word_t imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  task automatic put(input word_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  // Unused words are NOPs that carry their own index
  task automatic clear_program();
    for (int i = 0; i < MAX_WORDS; i++) begin
      prog[i] = enc_i(word_t'(i), 5'd0, 3'b000, 5'd0, OPC_OP_IMM);
    end
    prog_len = 0;
  endtask

  task automatic seed_regs();
    for (int r = 1; r < 8; r++) begin
      put(enc_i(lfsr_bits(12), 5'd0, 3'b000, reg_idx_t'(r), OPC_OP_IMM));
    end
  endtask

  task automatic gen_alu();
    logic [2:0] f3;
    reg_idx_t rd;
    word_t imm;
    logic alt;
    seed_regs();
    for (int i = 0; i < 24; i++) begin
      f3 = 3'(lfsr_bits(3));
      rd = reg_idx_t'(lfsr_bits(3));
      alt = (lfsr_bits(1) != 0);
      case (lfsr_bits(2))
        0: begin
          imm = lfsr_bits(12);
          // Shift immediates keep funct7 legal
          if (f3 == 3'b001 || f3 == 3'b101) begin
            imm = {20'd0, 1'b0, alt && f3 == 3'b101, 5'd0, 5'(lfsr_bits(5))};
          end
          put(enc_i(imm, reg_idx_t'(lfsr_bits(3)), f3, rd, OPC_OP_IMM));
        end
        1: begin
          put(enc_r((alt && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                    reg_idx_t'(lfsr_bits(3)), reg_idx_t'(lfsr_bits(3)), f3, rd));
        end
        2: put(enc_u(lfsr_bits(20), rd, OPC_LUI));
        default: put(enc_u(lfsr_bits(20), rd, OPC_AUIPC));
      endcase
      put(enc_s(lfsr_bits(9) << 2, rd, 5'd0));
    end
    put(ECALL);
  endtask

  task automatic gen_branch();
    for (int i = 0; i < 24; i++) begin
      put(enc_i(lfsr_bits(12), 5'd0, 3'b000, 5'd1, OPC_OP_IMM));
      if (lfsr_bits(2) == 0) begin
        put(enc_i(32'd0, 5'd1, 3'b000, 5'd2, OPC_OP_IMM));
      end else begin
        put(enc_i(lfsr_bits(12), 5'd0, 3'b000, 5'd2, OPC_OP_IMM));
      end
      // Forward skip of one or two instructions
      put(enc_b(32'd4 * (32'd2 + lfsr_bits(1)), 5'd2, 5'd1, BR_F3[i % 6]));
      put(enc_i(32'd1, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
      put(enc_i(32'd2, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
      put(enc_s(lfsr_bits(9) << 2, 5'd3, 5'd0));
    end
    put(ECALL);
  endtask

  task automatic gen_jump();
    reg_idx_t rd;
    for (int i = 0; i < 12; i++) begin
      rd = reg_idx_t'(lfsr_bits(3));
      put(enc_j(32'd8, rd));
      put(enc_i(32'd1, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
      put(enc_s(lfsr_bits(9) << 2, rd, 5'd0));
      // Base lands past the skipped word, offset adds low bits to be cleared
      put(enc_i(word_t'(4 * (prog_len + 3)), 5'd0, 3'b000, 5'd5, OPC_OP_IMM));
      put(enc_i(lfsr_bits(2), 5'd5, 3'b000, rd, OPC_JALR));
      put(enc_i(32'd1, 5'd3, 3'b000, 5'd3, OPC_OP_IMM));
      put(enc_s(lfsr_bits(9) << 2, rd, 5'd0));
    end
    put(ECALL);
  endtask

  task automatic gen_x0();
    seed_regs();
    for (int i = 0; i < 8; i++) begin
      put(enc_s((lfsr_bits(9) << 2) + 32'd1 + (lfsr_bits(2) % 3), 5'd1, 5'd0));
      put(enc_i(lfsr_bits(12), 5'd1, 3'b000, 5'd0, OPC_OP_IMM));
      put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
      put(enc_u(lfsr_bits(20), 5'd0, OPC_LUI));
      put(enc_s(lfsr_bits(9) << 2, 5'd0, 5'd0));
    end
    put(ECALL);
  endtask

  task automatic check_word(input string name, input string what, input word_t exp,
                            input word_t act);
    checks++;
    if (act !== exp) begin
      $display("ERR %s %s expected %h actual %h", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic check_bit(input string name, input string what, input logic exp,
                           input logic act);
    checks++;
    if (act !== exp) begin
      $display("ERR %s %s expected %b actual %b", name, what, exp, act);
      errors++;
    end
  endtask

  task automatic begin_reset();
    @(posedge clk);
    #2;
    rst = 1'b1;
    clear_program();
  endtask

  // Finishes reset, then runs until the model has sat on ECALL for a while
  task automatic run_test(input string name);
    int held;
    int cycles;
    int errs_before;
    held = 0;
    cycles = 0;
    errs_before = errors;
    repeat (3) begin
      @(negedge clk);
      check_bit(name, "store enable in reset", 1'b0, dmem_we);
      check_bit(name, "halt in reset", 1'b0, halt);
      @(posedge clk);
    end
    #2;
    rst = 1'b0;
    model_reset();
    while (held < HOLD_CYCLES) begin
      @(negedge clk);
      check_word(name, "pc", m_pc, pc);
      model_step(prog[m_pc[9:2]]);
      check_bit(name, "halt", exp_halt, halt);
      check_bit(name, "store enable", exp_we, dmem_we);
      if (exp_we) begin
        check_word(name, "store address", exp_addr, dmem_addr);
        check_word(name, "store data", exp_wdata, dmem_wdata);
      end
      if (exp_halt) begin
        held++;
      end
      cycles++;
    end
    $display("%s: %0d cycles, %0d errors", name, cycles, errors - errs_before);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(NUM_TESTS * (MAX_WORDS + 16) * CLK_PERIOD);
    $display("Run timed out before all tests finished");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    rst = 1'b1;
    errors = 0;
    checks = 0;
    lfsr_state = SEED;
    clear_program();
    begin_reset();
    put(ECALL);
    run_test("reset");
    begin_reset();
    gen_alu();
    run_test("alu");
    begin_reset();
    gen_branch();
    run_test("branch");
    begin_reset();
    gen_jump();
    run_test("jump");
    begin_reset();
    gen_x0();
    run_test("x0");
    begin_reset();
    // Aligned store at word 0 sits at o_pc while reset is held
    put(enc_s(32'd0, 5'd1, 5'd0));
    seed_regs();
    put(enc_s(32'd0, 5'd1, 5'd0));
    put(ECALL);
    run_test("halt");
    $display("%0d tests, %0d checks, %0d errors", NUM_TESTS, checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
